/* src/cat_consts.svh */
// fixed build constants; CAT_DATA_W must be 8 * CAT_KEEP_W and CAT_S_COUNT must not exceed 4
`ifndef CAT_CONSTS_SVH
`define CAT_CONSTS_SVH

// number of input streams joined into one frame
`define CAT_S_COUNT 3

// beat width in bits
`define CAT_DATA_W 32

// byte lanes per beat
`define CAT_KEEP_W 4

`endif

/* src/cat_pkg.sv */
// shared stream types; widths follow the macros in the constants header
`include "cat_consts.svh"

package cat_pkg;

    // one beat of payload
    typedef logic [`CAT_DATA_W-1:0] data_t;

    // byte lane enables, contiguous from lane 0 on every input beat
    typedef logic [`CAT_KEEP_W-1:0] keep_t;

    // byte position inside a beat
    typedef logic [$clog2(`CAT_KEEP_W)-1:0] lane_t;

    // index of the source currently granted
    typedef logic [1:0] sel_t;

endpackage

/* src/cat_stream_if.sv */
// byte stream with valid/ready handshake; a beat moves when tvalid and tready are both high
`timescale 1ns/1ps

interface cat_stream_if;

    cat_pkg::data_t tdata;
    cat_pkg::keep_t tkeep;
    logic           tvalid;
    logic           tlast;
    logic           tready;

    // driving side
    modport src (
        output tdata,
        output tkeep,
        output tvalid,
        output tlast,
        input  tready
    );

    // receiving side
    modport snk (
        input  tdata,
        input  tkeep,
        input  tvalid,
        input  tlast,
        output tready
    );

endinterface

/* src/frame_concat.sv */
// input keep must be contiguous from lane 0 and nonzero; unaligned input runs at half rate
`timescale 1ns/1ps
`include "cat_consts.svh"

module frame_concat (
    input  logic      clk,
    input  logic      rst,
    cat_stream_if.snk src [`CAT_S_COUNT],
    cat_stream_if.src dst
);

    // flattened source signals
    cat_pkg::data_t             s_tdata [`CAT_S_COUNT];
    cat_pkg::keep_t             s_tkeep [`CAT_S_COUNT];
    logic [`CAT_S_COUNT-1:0]    s_tvalid;
    logic [`CAT_S_COUNT-1:0]    s_tlast;

    cat_pkg::sel_t              sel_reg;
    cat_pkg::sel_t              sel_next;
    logic [`CAT_S_COUNT-1:0]    ready_reg;
    logic [`CAT_S_COUNT-1:0]    ready_next;

    // two-word holding register, the lower word is what dst sees
    logic [2*`CAT_DATA_W-1:0]   hold_data;
    logic [2*`CAT_DATA_W-1:0]   hold_data_next;
    logic [2*`CAT_KEEP_W-1:0]   hold_keep;
    logic [2*`CAT_KEEP_W-1:0]   hold_keep_next;
    logic [1:0]                 hold_last;
    logic [1:0]                 hold_last_next;
    cat_pkg::lane_t             offset_reg;
    cat_pkg::lane_t             offset_next;

    cat_pkg::data_t             cur_tdata;
    cat_pkg::keep_t             cur_tkeep;
    logic                       cur_tvalid;
    logic                       cur_tlast;
    logic                       accept;
    logic                       final_seg;
    logic [$clog2(`CAT_KEEP_W):0] byte_count;
    logic [$clog2(`CAT_KEEP_W):0] wr_pos;

    for (genvar i = 0; i < `CAT_S_COUNT; i++) begin : g_src
        assign s_tdata[i]    = src[i].tdata;
        assign s_tkeep[i]    = src[i].tkeep;
        assign s_tvalid[i]   = src[i].tvalid;
        assign s_tlast[i]    = src[i].tlast;
        assign src[i].tready = ready_reg[i];
    end

    // selected source
    assign cur_tdata  = s_tdata[sel_reg];
    assign cur_tkeep  = s_tkeep[sel_reg];
    assign cur_tvalid = s_tvalid[sel_reg];
    assign cur_tlast  = s_tlast[sel_reg];
    assign accept     = cur_tvalid && ready_reg[sel_reg];
    assign final_seg  = sel_reg == cat_pkg::sel_t'(`CAT_S_COUNT - 1);

    assign dst.tdata  = hold_data[`CAT_DATA_W-1:0];
    assign dst.tkeep  = hold_keep[`CAT_KEEP_W-1:0];
    assign dst.tvalid = hold_keep[`CAT_KEEP_W-1] || hold_last[0];
    assign dst.tlast  = hold_last[0];

    // highest set lane gives the byte count
    always_comb begin
        byte_count = '0;
        for (int k = 0; k < `CAT_KEEP_W; k++) begin
            if (cur_tkeep[k]) begin
                byte_count = ($clog2(`CAT_KEEP_W) + 1)'(k + 1);
            end
        end
    end

    // round robin, advance after each segment's tlast
    always_comb begin
        sel_next = sel_reg;
        if (accept && cur_tlast) begin
            if (final_seg) begin
                sel_next = '0;
            end else begin
                sel_next = cat_pkg::sel_t'(sel_reg + 1'b1);
            end
        end
    end

    always_comb begin
        hold_data_next = hold_data;
        hold_keep_next = hold_keep;
        hold_last_next = hold_last;
        offset_next    = offset_reg;
        wr_pos         = '0;

        // lower word leaves, upper word drops into its place
        if (dst.tvalid && dst.tready) begin
            hold_data_next[`CAT_DATA_W-1:0] = hold_data[2*`CAT_DATA_W-1:`CAT_DATA_W];
            hold_keep_next = {{`CAT_KEEP_W{1'b0}}, hold_keep[2*`CAT_KEEP_W-1:`CAT_KEEP_W]};
            hold_last_next = {1'b0, hold_last[1]};
        end

        if (accept) begin
            // a full or closed lower word pushes the write up one word
            wr_pos = {hold_keep_next[`CAT_KEEP_W-1] | hold_last_next[0], offset_reg};
            hold_data_next[wr_pos*(`CAT_DATA_W/`CAT_KEEP_W) +: `CAT_DATA_W] = cur_tdata;
            hold_keep_next[wr_pos +: `CAT_KEEP_W] = cur_tkeep;
            offset_next = offset_reg + cat_pkg::lane_t'(byte_count);

            // end of combined frame; next frame starts on a fresh word
            if (cur_tlast && final_seg) begin
                offset_next = '0;
                if (hold_keep_next[`CAT_KEEP_W]) begin
                    hold_last_next[1] = 1'b1;
                end else begin
                    hold_last_next[0] = 1'b1;
                end
            end
        end
    end

    // a whole beat always fits while the upper word is empty
    always_comb begin
        ready_next = '0;
        ready_next[sel_next] = !hold_keep_next[`CAT_KEEP_W] && s_tvalid[sel_next];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg    <= '0;
            ready_reg  <= '0;
            hold_keep  <= '0;
            hold_last  <= '0;
            offset_reg <= '0;
        end else begin
            sel_reg    <= sel_next;
            ready_reg  <= ready_next;
            hold_keep  <= hold_keep_next;
            hold_last  <= hold_last_next;
            offset_reg <= offset_next;
        end
        hold_data <= hold_data_next;
    end

endmodule

/* src/stream_skid_reg.sv */
// registered output with one spare entry; upstream ready lags by one cycle
`timescale 1ns/1ps

module stream_skid_reg (
    input  logic             clk,
    input  logic             rst,
    cat_stream_if.snk        up,
    output cat_pkg::data_t   tdata,
    output cat_pkg::keep_t   tkeep,
    output logic             tvalid,
    output logic             tlast,
    input  logic             tready
);

    logic           ready_reg;
    logic           ready_early;
    logic           up_xfer;

    // presented beat
    cat_pkg::data_t out_data;
    cat_pkg::keep_t out_keep;
    logic           out_last;
    logic           out_valid;
    logic           out_valid_next;

    // spare entry
    cat_pkg::data_t temp_data;
    cat_pkg::keep_t temp_keep;
    logic           temp_last;
    logic           temp_valid;
    logic           temp_valid_next;

    logic           load_out;
    logic           load_temp;
    logic           temp_to_out;

    assign up.tready = ready_reg;
    assign up_xfer   = up.tvalid && ready_reg;

    assign tdata  = out_data;
    assign tkeep  = out_keep;
    assign tvalid = out_valid;
    assign tlast  = out_last;

    // stay ready unless the spare entry could fill this cycle
    assign ready_early = tready || (!temp_valid && (!out_valid || !up_xfer));

    always_comb begin
        out_valid_next  = out_valid;
        temp_valid_next = temp_valid;
        load_out        = 1'b0;
        load_temp       = 1'b0;
        temp_to_out     = 1'b0;

        if (ready_reg) begin
            if (tready || !out_valid) begin
                out_valid_next = up.tvalid;
                load_out       = 1'b1;
            end else begin
                temp_valid_next = up.tvalid;
                load_temp       = 1'b1;
            end
        end else if (tready) begin
            // drain spare entry
            out_valid_next  = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_reg  <= 1'b0;
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            ready_reg  <= ready_early;
            out_valid  <= out_valid_next;
            temp_valid <= temp_valid_next;
        end

        if (load_out) begin
            out_data <= up.tdata;
            out_keep <= up.tkeep;
            out_last <= up.tlast;
        end else if (temp_to_out) begin
            out_data <= temp_data;
            out_keep <= temp_keep;
            out_last <= temp_last;
        end

        if (load_temp) begin
            temp_data <= up.tdata;
            temp_keep <= up.tkeep;
            temp_last <= up.tlast;
        end
    end

endmodule

/* src/concat_top.sv */
// joins one segment per source into one output frame; first output beat comes 2+ cycles late
`timescale 1ns/1ps
`include "cat_consts.svh"

module concat_top (
    input  logic                    clk,
    input  logic                    rst,

    // per-source input streams
    input  cat_pkg::data_t          s_tdata [`CAT_S_COUNT],
    input  cat_pkg::keep_t          s_tkeep [`CAT_S_COUNT],
    input  logic [`CAT_S_COUNT-1:0] s_tvalid,
    input  logic [`CAT_S_COUNT-1:0] s_tlast,
    output logic [`CAT_S_COUNT-1:0] s_tready,

    // combined output stream
    output cat_pkg::data_t          m_tdata,
    output cat_pkg::keep_t          m_tkeep,
    output logic                    m_tvalid,
    output logic                    m_tlast,
    input  logic                    m_tready
);

    cat_stream_if src_if [`CAT_S_COUNT] ();
    cat_stream_if mid_if ();

    for (genvar i = 0; i < `CAT_S_COUNT; i++) begin : g_in
        assign src_if[i].tdata  = s_tdata[i];
        assign src_if[i].tkeep  = s_tkeep[i];
        assign src_if[i].tvalid = s_tvalid[i];
        assign src_if[i].tlast  = s_tlast[i];
        assign s_tready[i]      = src_if[i].tready;
    end

    // select and repack
    frame_concat concat_i (
        .clk (clk),
        .rst (rst),
        .src (src_if),
        .dst (mid_if)
    );

    // output register, absorbs back-pressure
    stream_skid_reg skid_i (
        .clk    (clk),
        .rst    (rst),
        .up     (mid_if),
        .tdata  (m_tdata),
        .tkeep  (m_tkeep),
        .tvalid (m_tvalid),
        .tlast  (m_tlast),
        .tready (m_tready)
    );

endmodule

/* sim/concat_checker.sv */
// one combined frame per source rotation; only kept output lanes are compared
`timescale 1ns/1ps
`include "cat_consts.svh"

module concat_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  cat_pkg::data_t          s_tdata [`CAT_S_COUNT],
    input  cat_pkg::keep_t          s_tkeep [`CAT_S_COUNT],
    input  logic [`CAT_S_COUNT-1:0] s_tvalid,
    input  logic [`CAT_S_COUNT-1:0] s_tlast,
    input  logic [`CAT_S_COUNT-1:0] s_tready,
    input  cat_pkg::data_t          m_tdata,
    input  cat_pkg::keep_t          m_tkeep,
    input  logic                    m_tvalid,
    input  logic                    m_tlast,
    input  logic                    m_tready,
    output int                      error_count,
    output int                      beat_count,
    output int                      pending
);

    // bit 8 marks the final byte of a combined frame
    logic [8:0] byte_q [$];
    int         errors;
    int         beats;
    int         exp_src;

    function automatic cat_pkg::data_t lane_mask(input cat_pkg::keep_t keep);
        cat_pkg::data_t mask;
        mask = '0;
        for (int k = 0; k < `CAT_KEEP_W; k++) begin
            if (keep[k]) begin
                mask[8*k +: 8] = 8'hff;
            end
        end
        return mask;
    endfunction

    always @(posedge clk) begin
        logic [8:0]     b;
        cat_pkg::data_t exp_data;
        cat_pkg::keep_t exp_keep;
        logic           exp_last;
        int             n;
        if (rst) begin
            byte_q.delete();
            errors  = 0;
            beats   = 0;
            exp_src = 0;
        end else begin
            // accepted input bytes in arrival order
            for (int i = 0; i < `CAT_S_COUNT; i++) begin
                if (s_tvalid[i] && s_tready[i]) begin
                    if (i != exp_src) begin
                        errors++;
                        $display("source %0d accepted at %0d ns while source %0d owns the frame",
                            i, $time, exp_src);
                    end
                    for (int k = 0; k < `CAT_KEEP_W; k++) begin
                        if (s_tkeep[i][k]) begin
                            byte_q.push_back({1'b0, s_tdata[i][8*k +: 8]});
                        end
                    end
                    if (s_tlast[i]) begin
                        if (i == `CAT_S_COUNT - 1 && byte_q.size() > 0) begin
                            b = byte_q.pop_back();
                            byte_q.push_back({1'b1, b[7:0]});
                        end
                        exp_src = (i + 1) % `CAT_S_COUNT;
                    end
                end
            end

            // output beat takes up to one word, stopping at frame end
            if (m_tvalid && m_tready) begin
                exp_data = '0;
                exp_keep = '0;
                exp_last = 1'b0;
                n        = 0;
                while (n < `CAT_KEEP_W && byte_q.size() > 0 && !exp_last) begin
                    b = byte_q.pop_front();
                    exp_data[8*n +: 8] = b[7:0];
                    exp_keep[n]        = 1'b1;
                    exp_last           = b[8];
                    n++;
                end
                beats++;
                if (n == 0) begin
                    errors++;
                    $display("output beat at %0d ns with no accepted input bytes left", $time);
                end else begin
                    if (m_tkeep !== exp_keep) begin
                        errors++;
                        $display("mismatch at %0d ns: m_tkeep expected %h actual %h",
                            $time, exp_keep, m_tkeep);
                    end
                    if (m_tlast !== exp_last) begin
                        errors++;
                        $display("mismatch at %0d ns: m_tlast expected %b actual %b",
                            $time, exp_last, m_tlast);
                    end
                    if ((m_tdata & lane_mask(exp_keep)) !== exp_data) begin
                        errors++;
                        $display("mismatch at %0d ns: m_tdata expected %h actual %h",
                            $time, exp_data, m_tdata);
                    end
                end
            end
        end
        error_count <= errors;
        beat_count  <= beats;
        pending     <= byte_q.size();
    end

endmodule

/* sim/concat_assertions.sv */
// bound twice, on the output port and on the internal stage; payload checked on kept lanes only
`timescale 1ns/1ps
`include "cat_consts.svh"

module concat_assertions (
    input logic                    clk,
    input logic                    rst,
    input cat_pkg::data_t          tdata,
    input cat_pkg::keep_t          tkeep,
    input logic                    tvalid,
    input logic                    tlast,
    input logic                    tready,
    input logic [`CAT_S_COUNT-1:0] sel_ready
);

    cat_pkg::data_t kept_data;

    // failed assertion count
    int fail_count = 0;

    always_comb begin
        kept_data = '0;
        for (int k = 0; k < `CAT_KEEP_W; k++) begin
            if (tkeep[k]) begin
                kept_data[8*k +: 8] = tdata[8*k +: 8];
            end
        end
    end

    // stalled beat stays put
    a_hold_stable: assert property (
        @(posedge clk) disable iff (rst)
        tvalid && !tready |=> tvalid && $stable(kept_data) && $stable(tkeep) && $stable(tlast)
    ) else begin
        fail_count++;
        $error("stream beat changed while stalled");
    end

    a_one_ready: assert property (@(posedge clk) disable iff (rst) $onehot0(sel_ready))
        else begin
            fail_count++;
            $error("more than one source sees ready");
        end

    // dense packing, only the frame end may be partial
    a_full_keep: assert property (@(posedge clk) disable iff (rst) tvalid && !tlast |-> &tkeep)
        else begin
            fail_count++;
            $error("non-last beat with partial keep");
        end

endmodule

bind concat_top concat_assertions top_assert_i (
    .clk       (clk),
    .rst       (rst),
    .tdata     (m_tdata),
    .tkeep     (m_tkeep),
    .tvalid    (m_tvalid),
    .tlast     (m_tlast),
    .tready    (m_tready),
    .sel_ready (s_tready)
);

bind frame_concat concat_assertions mid_assert_i (
    .clk       (clk),
    .rst       (rst),
    .tdata     (dst.tdata),
    .tkeep     (dst.tkeep),
    .tvalid    (dst.tvalid),
    .tlast     (dst.tlast),
    .tready    (dst.tready),
    .sel_ready (ready_reg)
);

/* sim/concat_tb.sv */
// one combined frame per table row; every source offers its first beat from the row start
`timescale 1ns/1ps
`include "cat_consts.svh"

module concat_tb;

    localparam int ROWS    = 8;
    localparam int TIMEOUT = 1000;

    // segment byte lengths for sources 0, 1 and 2
    localparam int LEN_TABLE [ROWS][`CAT_S_COUNT] = '{
        '{4, 8, 12},
        '{1, 5, 7},
        '{3, 3, 3},
        '{8, 4, 16},
        '{5, 7, 1},
        '{3, 4, 6},
        '{7, 9, 10},
        '{2, 2, 4}
    };

    // 1 gives random output ready; row 5 spills its last bytes into a new word
    localparam bit RAND_READY [ROWS] = '{0, 0, 0, 1, 1, 0, 1, 1};

    logic                    clk;
    logic                    rst;
    cat_pkg::data_t          s_tdata [`CAT_S_COUNT];
    cat_pkg::keep_t          s_tkeep [`CAT_S_COUNT];
    logic [`CAT_S_COUNT-1:0] s_tvalid;
    logic [`CAT_S_COUNT-1:0] s_tlast;
    logic [`CAT_S_COUNT-1:0] s_tready;
    cat_pkg::data_t          m_tdata;
    cat_pkg::keep_t          m_tkeep;
    logic                    m_tvalid;
    logic                    m_tlast;
    logic                    m_tready;

    logic rand_ready;
    logic timed_out;
    int   tb_errors;
    int   chk_errors;
    int   beat_count;
    int   pending;

    always #4 clk = ~clk;

    concat_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .s_tdata  (s_tdata),
        .s_tkeep  (s_tkeep),
        .s_tvalid (s_tvalid),
        .s_tlast  (s_tlast),
        .s_tready (s_tready),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tvalid (m_tvalid),
        .m_tlast  (m_tlast),
        .m_tready (m_tready)
    );

    concat_checker chk_i (
        .clk         (clk),
        .rst         (rst),
        .s_tdata     (s_tdata),
        .s_tkeep     (s_tkeep),
        .s_tvalid    (s_tvalid),
        .s_tlast     (s_tlast),
        .s_tready    (s_tready),
        .m_tdata     (m_tdata),
        .m_tkeep     (m_tkeep),
        .m_tvalid    (m_tvalid),
        .m_tlast     (m_tlast),
        .m_tready    (m_tready),
        .error_count (chk_errors),
        .beat_count  (beat_count),
        .pending     (pending)
    );

    // every testbench edge passes here so output ready follows the row mode
    task automatic tick();
        @(posedge clk);
        if (rand_ready) begin
            m_tready <= ($urandom % 2) == 0;
        end else begin
            m_tready <= 1'b1;
        end
    endtask

    task automatic check_idle(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            tick();
            if (s_tready !== '0) begin
                tb_errors++;
                $display("mismatch at %0d ns: s_tready expected 0 actual %b", $time, s_tready);
            end
            if (m_tvalid !== 1'b0) begin
                tb_errors++;
                $display("mismatch at %0d ns: m_tvalid expected 0 actual %b", $time, m_tvalid);
            end
        end
    endtask

    // puts the next beat of a segment on one source
    task automatic offer_beat(input int src, input int left);
        int n;
        n = (left > `CAT_KEEP_W) ? `CAT_KEEP_W : left;
        s_tdata[src]  <= $urandom;
        s_tkeep[src]  <= cat_pkg::keep_t'((1 << n) - 1);
        s_tlast[src]  <= (left == n);
        s_tvalid[src] <= 1'b1;
    endtask

    // first beat is already on the source when this starts
    task automatic send_segment(input int src, input int len);
        int left;
        int n;
        int waited;
        left = len;
        while (left > 0 && !timed_out) begin
            n = (left > `CAT_KEEP_W) ? `CAT_KEEP_W : left;
            waited = 0;
            tick();
            while (!s_tready[src] && waited < TIMEOUT) begin
                waited++;
                tick();
            end
            if (!s_tready[src]) begin
                timed_out = 1'b1;
                $display("timeout: source %0d never accepted a beat", src);
            end
            left -= n;
            if (left > 0) begin
                offer_beat(src, left);
            end
        end
        s_tvalid[src] <= 1'b0;
        s_tlast[src]  <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((pending != 0 || m_tvalid) && waited < TIMEOUT) begin
            waited++;
            tick();
        end
        if (pending != 0 || m_tvalid) begin
            timed_out = 1'b1;
            $display("timeout: output never drained, %0d bytes still expected", pending);
        end
    endtask

    initial begin
        int total;
        int start_beats;
        int exp_beats;
        int assert_errors;
        clk        = 1'b0;
        rst        = 1'b1;
        s_tvalid   = '0;
        s_tlast    = '0;
        m_tready   = 1'b1;
        rand_ready = 1'b0;
        timed_out  = 1'b0;
        tb_errors  = 0;
        for (int i = 0; i < `CAT_S_COUNT; i++) begin
            s_tdata[i] = '0;
            s_tkeep[i] = '0;
        end
        void'($urandom(90804));

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        check_idle(4);

        for (int r = 0; r < ROWS && !timed_out; r++) begin
            rand_ready  = RAND_READY[r];
            start_beats = beat_count;
            total       = 0;
            // later sources wait with valid high until their turn
            for (int s = 0; s < `CAT_S_COUNT; s++) begin
                offer_beat(s, LEN_TABLE[r][s]);
                total += LEN_TABLE[r][s];
            end
            for (int s = 0; s < `CAT_S_COUNT && !timed_out; s++) begin
                send_segment(s, LEN_TABLE[r][s]);
            end
            if (!timed_out) begin
                wait_drain();
            end
            // whole beats, rounded up
            exp_beats = (total + `CAT_KEEP_W - 1) / `CAT_KEEP_W;
            if (!timed_out && beat_count - start_beats != exp_beats) begin
                tb_errors++;
                $display("mismatch at %0d ns: row %0d output beat count expected %0d actual %0d",
                    $time, r, exp_beats, beat_count - start_beats);
            end
        end

        assert_errors = dut_i.top_assert_i.fail_count + dut_i.concat_i.mid_assert_i.fail_count;
        $display("error counts: checker %0d, testbench %0d, assertions %0d",
            chk_errors, tb_errors, assert_errors);
        if (chk_errors == 0 && tb_errors == 0 && assert_errors == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+src
src/cat_pkg.sv
src/cat_stream_if.sv
src/frame_concat.sv
src/stream_skid_reg.sv
src/concat_top.sv
sim/concat_checker.sv
sim/concat_assertions.sv
sim/concat_tb.sv
